/* verilog/palette_mem_pkg.sv */
`default_nettype none

// what the loader sees of the external memory master
package palette_mem_pkg;

  // one byte per read transfer, Doom lumps are byte streams
  typedef logic [7:0] mem_byte_t;                   // read data of the master

  // host address space is 32-bit bytes
  localparam int ADDR_WIDTH_DEFAULT = 32;           // top level default

  // address vectors are sized by the ADDR_WIDTH module parameter,
  // not by a typedef here, so a narrower bus only needs the top level changed

endpackage

`default_nettype wire

/* verilog/palette_color_pkg.sv */
`default_nettype none

// palette entries, colour channels and the loader state encoding
package palette_color_pkg;

  typedef logic [7:0]  color_index_t;               // entry number == pixel value
  typedef logic [7:0]  channel_t;                   // one intensity byte
  typedef logic [1:0]  channel_sel_t;               // r, g or b of an entry
  typedef logic [23:0] rgb_t;                       // {red, green, blue}

  localparam int NUM_CHANNELS    = 3;               // r, g, b banks
  localparam int PALETTE_BYTES   = 768;             // bytes in one PLAYPAL load
  localparam int PALETTE_ENTRIES = PALETTE_BYTES / NUM_CHANNELS; // 256 entries

  localparam channel_sel_t CH_RED   = 2'd0;         // first byte of an entry
  localparam channel_sel_t CH_GREEN = 2'd1;
  localparam channel_sel_t CH_BLUE  = 2'd2;         // last byte of an entry

  // final entry of a load, entry 255 included
  localparam color_index_t LAST_ENTRY = color_index_t'(PALETTE_ENTRIES - 1);

  // read stays high for the whole load, so two states are enough
  typedef enum logic [0:0] {
    LOADER_IDLE,                                    // waiting for start
    LOADER_READING                                  // streaming 768 bytes
  } loader_state_t;

endpackage

`default_nettype wire

/* verilog/palette_bank.sv */
`default_nettype none

module palette_bank
  import palette_color_pkg::*;
(
  input  wire          clk,

  input  wire          write,                       // from the loader
  input  wire color_index_t write_index,            // entry being filled
  input  wire channel_t write_data,

  input  wire color_index_t read_index,             // from the lookup stage
  output channel_t     read_data                    // one cycle after read_index
);

  channel_t mem [0:PALETTE_ENTRIES-1];              // one channel of every entry

  always_ff @(posedge clk) begin
    if (write) begin
      mem[write_index] <= write_data;               // loader port
    end
    read_data <= mem[read_index];                   // old value on a same-index write
  end

endmodule

`default_nettype wire

/* verilog/palette_loader.sv */
`default_nettype none

module palette_loader
  import palette_mem_pkg::*, palette_color_pkg::*;
#(
  parameter int ADDR_WIDTH = ADDR_WIDTH_DEFAULT     // byte address width
) (
  input  wire                    clk,
  input  wire                    reset,             // sync, active high

  input  wire                    start,             // one-cycle request
  input  wire   [ADDR_WIDTH-1:0] palette_base,      // first byte, from host params
  output logic                   busy,              // high for the whole load

  output logic  [ADDR_WIDTH-1:0] mem_address,       // registered, held under wait
  output logic                   mem_read,          // held high across bytes
  input  wire                    mem_waitrequest,   // only back-pressure
  input  wire   mem_byte_t       mem_readdata,      // valid with an accepted read

  output logic  [NUM_CHANNELS-1:0] bank_write,      // one-hot per channel
  output color_index_t           bank_write_index,  // entry being filled
  output channel_t               bank_write_data    // byte straight from memory
);

  loader_state_t             state;                 // idle or reading
  logic         [ADDR_WIDTH-1:0] address;           // byte on the bus
  color_index_t              entry;                 // entry the byte belongs to
  channel_sel_t              chan;                  // channel the byte belongs to
  channel_sel_t              chan_next;             // wrap 0, 1, 2
  logic [NUM_CHANNELS-1:0]   chan_onehot;           // decoded channel
  logic                      reading;               // state decode
  logic                      accept;                // byte taken this cycle
  logic                      last_byte;             // blue of entry 255

  assign reading   = (state == LOADER_READING);
  assign accept    = reading && !mem_waitrequest;   // read is high while reading
  assign last_byte = accept && (chan == CH_BLUE) && (entry == LAST_ENTRY);

  // replaces the mod-3 bit trick with a plain compare
  assign chan_next   = (chan == CH_BLUE) ? CH_RED : chan + 2'd1;
  assign chan_onehot = NUM_CHANNELS'(1) << chan;    // bank select

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= LOADER_IDLE;
      address <= '0;
      entry   <= '0;
      chan    <= CH_RED;
    end else begin
      case (state)
        LOADER_IDLE: begin
          if (start) begin                          // base sampled only here
            state   <= LOADER_READING;
            address <= palette_base;
            entry   <= '0;
            chan    <= CH_RED;
          end
        end

        LOADER_READING: begin                       // start ignored while busy
          if (accept) begin
            address <= address + ADDR_WIDTH'(1);    // byte k at base + k
            chan    <= chan_next;
            if (chan == CH_BLUE) begin
              entry <= entry + 8'd1;                // next entry after blue
            end
            if (last_byte) begin
              state <= LOADER_IDLE;                 // read drops next cycle
            end
          end
        end

        default: begin
          state <= LOADER_IDLE;                     // recover from bad encoding
        end
      endcase
    end
  end

  assign busy        = reading;
  assign mem_read    = reading;
  assign mem_address = address;

  // bank write lands in the same cycle the byte is accepted
  assign bank_write       = accept ? chan_onehot : '0;
  assign bank_write_index = entry;
  assign bank_write_data  = mem_readdata;           // gamma is identity in Doom

endmodule

`default_nettype wire

/* verilog/palette_lookup.sv */
`default_nettype none

module palette_lookup
  import palette_color_pkg::*;
(
  input  wire                 clk,
  input  wire                 reset,                // sync, active high

  input  wire                 pixel_valid,          // one pixel per cycle max
  input  wire                 pixel_blank,          // force black
  input  wire   color_index_t pixel_index,          // 8-bit Doom pixel

  output color_index_t        bank_read_index,      // address to all banks
  input  wire   channel_t [NUM_CHANNELS-1:0] bank_read_data, // r, g, b one cycle later

  output logic                color_valid,          // pixel_valid delayed by 2
  output rgb_t                color                 // registered 24-bit colour
);

  logic [1:0] valid_sr;                             // [0] with bank data, [1] with output
  logic       blank_d1;                             // lines up with bank data
  rgb_t       color_next;                           // packed bank data or black

  // banks register the read, so the index goes out unregistered
  assign bank_read_index = pixel_index;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[0], pixel_valid};       // two in flight at most
    end
  end

  always_ff @(posedge clk) begin
    blank_d1 <= pixel_blank;                        // payload, only meaningful with valid
  end

  assign color_next = blank_d1 ? '0 :
                      {bank_read_data[CH_RED],      // red in the top byte
                       bank_read_data[CH_GREEN],
                       bank_read_data[CH_BLUE]};

  always_ff @(posedge clk) begin
    if (valid_sr[0]) begin
      color <= color_next;                          // hold between pixels
    end
  end

  assign color_valid = valid_sr[1];

endmodule

`default_nettype wire

/* verilog/palette_subsystem.sv */
`default_nettype none

module palette_subsystem
  import palette_mem_pkg::*, palette_color_pkg::*;
#(
  parameter int ADDR_WIDTH = ADDR_WIDTH_DEFAULT     // memory byte address width
) (
  input  wire                  clk,
  input  wire                  reset,               // sync, active high

  input  wire                  start,               // load request pulse
  input  wire [ADDR_WIDTH-1:0] palette_base,        // PLAYPAL address from host
  output wire                  busy,                // load in progress

  output wire [ADDR_WIDTH-1:0] mem_address,         // read master
  output wire                  mem_read,
  input  wire                  mem_waitrequest,
  input  wire mem_byte_t       mem_readdata,

  input  wire                  pixel_valid,         // pixel stream in
  input  wire                  pixel_blank,
  input  wire color_index_t    pixel_index,

  output wire                  color_valid,         // colour stream out, 2 cycles later
  output wire rgb_t            color
);

  logic [NUM_CHANNELS-1:0]   bank_write;            // one enable per bank
  color_index_t              bank_write_index;      // shared by all banks
  channel_t                  bank_write_data;       // shared by all banks
  color_index_t              bank_read_index;       // shared by all banks
  channel_t [NUM_CHANNELS-1:0] bank_read_data;      // r, g, b from the banks

  palette_loader #(
    .ADDR_WIDTH       (ADDR_WIDTH)
  ) u_loader (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .palette_base     (palette_base),
    .busy             (busy),
    .mem_address      (mem_address),
    .mem_read         (mem_read),
    .mem_waitrequest  (mem_waitrequest),
    .mem_readdata     (mem_readdata),
    .bank_write       (bank_write),
    .bank_write_index (bank_write_index),
    .bank_write_data  (bank_write_data)
  );

  // bank c holds channel c of every entry
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_bank
    palette_bank u_bank (
      .clk         (clk),
      .write       (bank_write[c]),                 // enable bit c
      .write_index (bank_write_index),
      .write_data  (bank_write_data),
      .read_index  (bank_read_index),
      .read_data   (bank_read_data[c])
    );
  end

  palette_lookup u_lookup (
    .clk             (clk),
    .reset           (reset),
    .pixel_valid     (pixel_valid),
    .pixel_blank     (pixel_blank),
    .pixel_index     (pixel_index),
    .bank_read_index (bank_read_index),
    .bank_read_data  (bank_read_data),
    .color_valid     (color_valid),
    .color           (color)
  );

endmodule

`default_nettype wire

/* test/palette_subsystem_assert.sv */
`default_nettype none

module palette_subsystem_assert
  import palette_color_pkg::*;
#(
  parameter int ADDR_WIDTH = 32                     // loader bus width
) (
  input wire                  clk,
  input wire                  reset,
  input wire loader_state_t   state,                // loader fsm
  input wire                  start,                // load request
  input wire                  mem_read,
  input wire                  mem_waitrequest,
  input wire [ADDR_WIDTH-1:0] mem_address,
  input wire                  pixel_valid,          // lookup side
  input wire                  color_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled read keeps its address
  address_stable_under_wait: assert property (@(posedge clk) disable iff (reset)
    (mem_read && mem_waitrequest) |=> $stable(mem_address))
    else $error("mem_address changed while mem_waitrequest was high");

  // idle without a start stays idle, no read request next cycle
  no_read_without_start: assert property (@(posedge clk) disable iff (reset)
    (state == LOADER_IDLE && !start) |=> !mem_read)
    else $error("mem_read raised without a start seen in idle");

  valid_after_two: assert property (@(posedge clk) disable iff (reset)
    pixel_valid |-> ##2 color_valid)
    else $error("color_valid missing two cycles after pixel_valid");

  no_stray_valid: assert property (@(posedge clk) disable iff (reset)
    color_valid |-> $past(pixel_valid, 2))
    else $error("color_valid without pixel_valid two cycles before");

endmodule

// loader copy watches the bus, lookup side tied off
bind palette_loader palette_subsystem_assert #(.ADDR_WIDTH(ADDR_WIDTH)) u_loader_assert (
  .clk(clk), .reset(reset), .state(state), .start(start), .mem_read(mem_read),
  .mem_waitrequest(mem_waitrequest), .mem_address(mem_address),
  .pixel_valid(1'b0), .color_valid(1'b0)
);

// lookup copy watches latency, bus side tied off
bind palette_lookup palette_subsystem_assert u_lookup_assert (
  .clk(clk), .reset(reset), .state(LOADER_IDLE), .start(1'b0), .mem_read(1'b0),
  .mem_waitrequest(1'b0), .mem_address('0),
  .pixel_valid(pixel_valid), .color_valid(color_valid)
);

`default_nettype wire

/* test/palette_subsystem_tb.sv */
`default_nettype none

module palette_subsystem_tb
  import palette_mem_pkg::*, palette_color_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_SIZE      = 16384;             // covers every test base
  localparam int LOAD_TIMEOUT  = 4000;              // cycles, random waits included
  localparam int DRAIN_TIMEOUT = 20;

  logic clk, reset, start, busy, mem_read, mem_waitrequest;
  logic [31:0] palette_base, mem_address;
  mem_byte_t mem_readdata;
  logic pixel_valid, pixel_blank, color_valid;
  color_index_t pixel_index;
  rgb_t color;

  mem_byte_t   mem [0:MEM_SIZE-1];                  // external memory model
  bit          wait_mode;                           // 1 = random wait request
  int          accept_count, wait_count, cycle;
  logic [31:0] first_address, loaded_base;          // base the banks should hold
  rgb_t        exp_color_q[$];                      // scoreboard
  int          exp_cycle_q[$];                      // issue cycle of each pixel
  int          errors, checks, tests_run, tests_bad;

  palette_subsystem #(.ADDR_WIDTH(32)) u_dut (
    .clk(clk), .reset(reset), .start(start), .palette_base(palette_base), .busy(busy),
    .mem_address(mem_address), .mem_read(mem_read), .mem_waitrequest(mem_waitrequest),
    .mem_readdata(mem_readdata), .pixel_valid(pixel_valid), .pixel_blank(pixel_blank),
    .pixel_index(pixel_index), .color_valid(color_valid), .color(color)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                         // 100 ns period
  end

  assign mem_readdata = mem_waitrequest ? 8'h00 : mem[mem_address[13:0]];

  always @(negedge clk) begin
    mem_waitrequest <= wait_mode && ($urandom_range(0, 2) == 0); // ~1 in 3 stalls
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic rgb_t expected_color(input logic [31:0] base, input color_index_t idx,
                                          input logic blank);
    logic [31:0] a;
    a = base + 32'(idx) * 3;                        // entry i at base + 3i
    if (blank) return '0;
    return {mem[a[13:0]], mem[(a + 32'd1) & (MEM_SIZE - 1)], mem[(a + 32'd2) & (MEM_SIZE - 1)]};
  endfunction

  // bus and pixel monitor, sampled on the rising edge
  always @(posedge clk) begin
    if (!reset && mem_read && mem_waitrequest) wait_count++;
    if (!reset && mem_read && !mem_waitrequest) begin
      if (accept_count == 0) first_address = mem_address;
      else check_value("mem_address", mem_address, first_address + accept_count);
      accept_count++;
    end
    if (!reset && color_valid) begin
      if (exp_color_q.size() == 0) begin
        $display("color_valid at %0t with no pixel in flight", $time);
        errors++;
      end else begin
        check_value("color", color, exp_color_q.pop_front());
        check_value("color_valid latency", cycle - exp_cycle_q.pop_front(), 2);
      end
    end
    if (!reset && pixel_valid) begin
      exp_color_q.push_back(expected_color(loaded_base, pixel_index, pixel_blank));
      exp_cycle_q.push_back(cycle);
    end
    cycle++;
  end

  task automatic run_load(input logic [31:0] base, input bit random_wait, input int restart_at,
                          input logic [31:0] restart_base, output int cycles);
    @(posedge clk);
    wait_mode = random_wait;                        // away from the driver's edge
    @(negedge clk);
    accept_count = 0;
    wait_count   = 0;
    start        = 1'b1;
    palette_base = base;
    @(negedge clk);
    start        = 1'b0;
    palette_base = 32'h0dea_0000;                   // must not be sampled now
    cycles = 0;
    while (busy && cycles < LOAD_TIMEOUT) begin
      start = (cycles == restart_at);               // pulse while busy
      if (cycles == restart_at) palette_base = restart_base;
      cycles++;
      @(negedge clk);
    end
    start = 1'b0;
    if (busy) begin
      $display("load from base %h did not finish within %0d cycles", base, LOAD_TIMEOUT);
      errors++;
    end
  endtask

  task automatic drain_colors();
    int waited;
    waited = 0;
    while (exp_color_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_color_q.size() != 0) begin
      $display("%0d colours never came out of the lookup stage", exp_color_q.size());
      errors++;
      exp_color_q.delete();
      exp_cycle_q.delete();
    end
  endtask

  task automatic send_pixels(input int count, input bit sequential, input bit mixed_blank);
    for (int i = 0; i < count; i++) begin
      pixel_valid = 1'b1;                           // back to back
      pixel_index = sequential ? color_index_t'(i) : color_index_t'($urandom);
      pixel_blank = mixed_blank && ($urandom_range(0, 2) == 0);
      @(negedge clk);
    end
    pixel_valid = 1'b0;
    pixel_blank = 1'b0;
    drain_colors();
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %-20s ok", name);
    end else begin
      tests_bad++;
      $display("test %-20s %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_value("busy", busy, 0);
    check_value("mem_read", mem_read, 0);
    check_value("color_valid", color_valid, 0);
    report_test("reset", e0);
  endtask

  task automatic test_load(input string name, input logic [31:0] base, input bit random_wait,
                           input int restart_at, input logic [31:0] restart_base);
    int e0, cycles;
    e0 = errors;
    run_load(base, random_wait, restart_at, restart_base, cycles);
    check_value("load cycles", cycles, 768 + wait_count); // wait_count 0 without stalls
    check_value("accepted reads", accept_count, PALETTE_BYTES);
    check_value("first mem_address", first_address, base);
    loaded_base = base;
    send_pixels(256, 1'b1, 1'b0);                   // every entry once
    report_test(name, e0);
  endtask

  task automatic test_lookup_pipeline();
    int e0;
    e0 = errors;
    send_pixels(64, 1'b0, 1'b1);                    // random index, some blanked
    report_test("lookup pipeline", e0);
  endtask

  initial begin
    void'($urandom(32'hf15d));                      // one seed for the run
    reset = 1'b1;
    start = 1'b0;
    palette_base = '0;
    pixel_valid = 1'b0;
    pixel_blank = 1'b0;
    pixel_index = '0;
    wait_mode = 1'b0;
    mem_waitrequest = 1'b0;
    loaded_base = '0;
    for (int a = 0; a < MEM_SIZE; a++) mem[a] = mem_byte_t'($urandom);
    repeat (16) @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_load("zero wait load", 32'h0000_1000, 1'b0, -1, '0);
    test_load("random wait load", 32'h0000_2345, 1'b1, -1, '0);
    test_lookup_pipeline();
    test_load("start during load", 32'h0000_0400, 1'b1, 300, 32'h0000_3000);
    $display("tests %0d, with errors %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* palette_subsystem.f */
verilog/palette_mem_pkg.sv
verilog/palette_color_pkg.sv
verilog/palette_bank.sv
verilog/palette_loader.sv
verilog/palette_lookup.sv
verilog/palette_subsystem.sv
test/palette_subsystem_assert.sv
test/palette_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the palette subsystem testbench

VERILATOR ?= verilator
TOP       ?= palette_subsystem_tb
FILELIST  ?= palette_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
